/* source/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data path and address width
`define XLEN 32

// Register index width
`define REG_ADDR_W 5

// Data RAM word index, 256 words
`define DMEM_ADDR_W 8

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    OR  = 4'd3,
    XOR = 4'd4,
    SLT = 4'd5
  } alu_op_e;

  typedef enum logic [1:0] {
    NONE = 2'd0,
    EQ   = 2'd1,
    NE   = 2'd2
  } branch_e;

  // Function fields
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_WORD    = 3'b010;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

endpackage

`default_nettype wire

/* source/pipeline_pkg.sv */
`default_nettype none

`include "core_defines.svh"

package pipeline_pkg;

  // Fetch to decode
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] inst;
    logic             valid;
  } if_id_t;

  // Decode to execute
  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    isa_pkg::alu_op_e       alu_op;
    isa_pkg::branch_e       branch;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm;
    logic                   use_imm;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   valid;
  } id_ex_t;

  // Execute to memory
  typedef struct packed {
    logic [`XLEN-1:0]       alu_result;
    logic [`XLEN-1:0]       store_data;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
  } ex_mem_t;

  // Memory to writeback
  typedef struct packed {
    logic [`XLEN-1:0]       wb_data;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   reg_write;
  } mem_wb_t;

  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_MEM  = 2'd1,
    FWD_WB   = 2'd2
  } fwd_sel_e;

endpackage

`default_nettype wire

/* source/fetch_stage.sv */
`default_nettype none

`include "core_defines.svh"

module fetch_stage
  import pipeline_pkg::*;
(
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic [`XLEN-1:0] inst_i,
  input  wire logic             stall_i,
  input  wire logic             flush_i,
  input  wire logic [`XLEN-1:0] target_i,
  output logic      [`XLEN-1:0] fetch_pc_o,
  output if_id_t                if_id_o
);

  logic [`XLEN-1:0] pc_q;

  assign fetch_pc_o = pc_q;

  // Redirect has priority over a held PC
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= `RESET_PC;
    end else if (flush_i) begin
      pc_q <= target_i;
    end else if (!stall_i) begin
      pc_q <= pc_q + `XLEN'(4);
    end
  end

  // The word on inst_i belongs to pc_q in this cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      if_id_o <= '{pc: `RESET_PC, inst: `NOP_INST, valid: 1'b0};
    end else if (flush_i) begin
      if_id_o.inst  <= `NOP_INST;
      if_id_o.valid <= 1'b0;
    end else if (!stall_i) begin
      if_id_o <= '{pc: pc_q, inst: inst_i, valid: 1'b1};
    end
  end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`default_nettype none

`include "core_defines.svh"

module decode_stage
  import isa_pkg::*;
  import pipeline_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire if_id_t                 if_id_i,
  input  wire logic [`XLEN-1:0]       rs1_data_i,
  input  wire logic [`XLEN-1:0]       rs2_data_i,
  input  wire logic                   stall_i,
  input  wire logic                   flush_i,
  output logic      [`REG_ADDR_W-1:0] rs1_addr_o,
  output logic      [`REG_ADDR_W-1:0] rs2_addr_o,
  output id_ex_t                      id_ex_o
);

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] inst;
  logic             f3_ok;
  id_ex_t           dec;

  assign inst   = if_id_i.inst;
  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign f3_ok  = funct3 inside {F3_ADD_SUB, F3_SLT, F3_XOR, F3_OR, F3_AND};

  function automatic alu_op_e alu_of(input logic [2:0] f3);
    case (f3)
      F3_SLT:  return SLT;
      F3_XOR:  return XOR;
      F3_OR:   return OR;
      F3_AND:  return AND;
      default: return ADD;
    endcase
  endfunction

  always_comb begin
    logic legal;
    logic uses_rs2;

    legal    = 1'b0;
    uses_rs2 = 1'b0;
    dec      = '0;
    dec.pc   = if_id_i.pc;
    dec.rd   = inst[11:7];
    dec.rs1  = inst[19:15];
    dec.alu_op = ADD;
    dec.branch = NONE;
    case (opcode)
      OP: begin
        legal = f3_ok && (funct7 == F7_BASE || (funct7 == F7_SUB && funct3 == F3_ADD_SUB));
        uses_rs2 = 1'b1;
        dec.alu_op = (funct7 == F7_SUB) ? SUB : alu_of(funct3);
        dec.reg_write = 1'b1;
      end
      OP_IMM: begin
        legal = f3_ok;
        dec.alu_op = alu_of(funct3);
        dec.imm = {{20{inst[31]}}, inst[31:20]};
        dec.use_imm = 1'b1;
        dec.reg_write = 1'b1;
      end
      LOAD: begin
        legal = (funct3 == F3_WORD);
        dec.imm = {{20{inst[31]}}, inst[31:20]};
        dec.use_imm = 1'b1;
        dec.mem_read = 1'b1;
        dec.reg_write = 1'b1;
      end
      STORE: begin
        legal = (funct3 == F3_WORD);
        uses_rs2 = 1'b1;
        dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        dec.use_imm = 1'b1;
        dec.mem_write = 1'b1;
      end
      BRANCH: begin
        legal = (funct3 == F3_BEQ || funct3 == F3_BNE);
        uses_rs2 = 1'b1;
        dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        dec.branch = (funct3 == F3_BNE) ? NE : EQ;
      end
      default: ;
    endcase

    dec.rs2 = uses_rs2 ? inst[24:20] : '0;
    // Writes to x0 are dropped here and nowhere else
    if (dec.rd == '0) begin
      dec.reg_write = 1'b0;
    end
    dec.valid = legal && if_id_i.valid;
    // Unknown or empty slots go down the pipe as a NOP
    if (!dec.valid) begin
      dec.rs1       = '0;
      dec.rs2       = '0;
      dec.reg_write = 1'b0;
      dec.mem_read  = 1'b0;
      dec.mem_write = 1'b0;
      dec.branch    = NONE;
    end
  end

  assign rs1_addr_o = dec.rs1;
  assign rs2_addr_o = dec.rs2;

  always_ff @(posedge clk_i) begin
    if (rst_i || stall_i || flush_i) begin
      id_ex_o.valid     <= 1'b0;
      id_ex_o.reg_write <= 1'b0;
      id_ex_o.mem_read  <= 1'b0;
      id_ex_o.mem_write <= 1'b0;
      id_ex_o.branch    <= NONE;
    end else begin
      id_ex_o          <= dec;
      id_ex_o.rs1_data <= rs1_data_i;
      id_ex_o.rs2_data <= rs2_data_i;
    end
  end

endmodule

`default_nettype wire

/* source/register_file.sv */
`default_nettype none

`include "core_defines.svh"

module register_file (
  input  wire logic                   clk_i,
  input  wire logic [`REG_ADDR_W-1:0] rs1_addr_i,
  input  wire logic [`REG_ADDR_W-1:0] rs2_addr_i,
  input  wire pipeline_pkg::mem_wb_t  wb_i,
  output logic      [`XLEN-1:0]       rs1_data_o,
  output logic      [`XLEN-1:0]       rs2_data_o
);

  logic [`XLEN-1:0] regs [2**`REG_ADDR_W];

  // x0 never gets a reg_write from decode
  always_ff @(posedge clk_i) begin
    if (wb_i.reg_write) begin
      regs[wb_i.rd] <= wb_i.wb_data;
    end
  end

  // Same-cycle write is visible to decode
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                      (wb_i.reg_write && wb_i.rd == rs1_addr_i) ? wb_i.wb_data :
                      regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                      (wb_i.reg_write && wb_i.rd == rs2_addr_i) ? wb_i.wb_data :
                      regs[rs2_addr_i];

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`default_nettype none

`include "core_defines.svh"

module execute_stage
  import isa_pkg::*;
  import pipeline_pkg::*;
(
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire id_ex_t           id_ex_i,
  input  wire fwd_sel_e         fwd_a_i,
  input  wire fwd_sel_e         fwd_b_i,
  input  wire logic [`XLEN-1:0] mem_fwd_i,
  input  wire mem_wb_t          wb_i,
  output logic                  branch_taken_o,
  output logic      [`XLEN-1:0] target_o,
  output ex_mem_t               ex_mem_o
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] rs2_val;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_result;
  logic             cond;

  function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                               input logic [`XLEN-1:0] reg_val,
                                               input logic [`XLEN-1:0] mem_val,
                                               input logic [`XLEN-1:0] wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // ==========================================================
  // Operands
  // ==========================================================
  assign op_a    = fwd_mux(fwd_a_i, id_ex_i.rs1_data, mem_fwd_i, wb_i.wb_data);
  // Also the store data
  assign rs2_val = fwd_mux(fwd_b_i, id_ex_i.rs2_data, mem_fwd_i, wb_i.wb_data);
  assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;

  always_comb begin
    case (id_ex_i.alu_op)
      SUB:     alu_result = op_a - op_b;
      AND:     alu_result = op_a & op_b;
      OR:      alu_result = op_a | op_b;
      XOR:     alu_result = op_a ^ op_b;
      SLT:     alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_result = op_a + op_b;
    endcase
  end

  // ==========================================================
  // Branch resolution, not-taken is the prediction
  // ==========================================================
  always_comb begin
    case (id_ex_i.branch)
      EQ:      cond = (op_a == rs2_val);
      NE:      cond = (op_a != rs2_val);
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken_o = id_ex_i.valid && cond;
  assign target_o       = id_ex_i.pc + id_ex_i.imm;

  always_ff @(posedge clk_i) begin
    ex_mem_o.alu_result <= alu_result;
    ex_mem_o.store_data <= rs2_val;
    ex_mem_o.rd         <= id_ex_i.rd;
    if (rst_i) begin
      ex_mem_o.reg_write <= 1'b0;
      ex_mem_o.mem_read  <= 1'b0;
      ex_mem_o.mem_write <= 1'b0;
    end else begin
      ex_mem_o.reg_write <= id_ex_i.valid && id_ex_i.reg_write;
      ex_mem_o.mem_read  <= id_ex_i.valid && id_ex_i.mem_read;
      ex_mem_o.mem_write <= id_ex_i.valid && id_ex_i.mem_write;
    end
  end

endmodule

`default_nettype wire

/* source/memory_stage.sv */
`default_nettype none

`include "core_defines.svh"

module memory_stage
  import pipeline_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_i,
  input  wire ex_mem_t ex_mem_i,
  output mem_wb_t      mem_wb_o
);

  logic [`XLEN-1:0]        dmem [2**`DMEM_ADDR_W];
  logic [`DMEM_ADDR_W-1:0] word_addr;
  logic [`XLEN-1:0]        load_data;

  // Word index, wraps at the RAM size
  assign word_addr = ex_mem_i.alu_result[`DMEM_ADDR_W+1:2];

  always_ff @(posedge clk_i) begin
    if (ex_mem_i.mem_write) begin
      dmem[word_addr] <= ex_mem_i.store_data;
    end
  end

  // Asynchronous read
  assign load_data = dmem[word_addr];

  always_ff @(posedge clk_i) begin
    mem_wb_o.wb_data <= ex_mem_i.mem_read ? load_data : ex_mem_i.alu_result;
    mem_wb_o.rd      <= ex_mem_i.rd;
    if (rst_i) begin
      mem_wb_o.reg_write <= 1'b0;
    end else begin
      mem_wb_o.reg_write <= ex_mem_i.reg_write;
    end
  end

endmodule

`default_nettype wire

/* source/hazard_control.sv */
`default_nettype none

`include "core_defines.svh"

module hazard_control
  import pipeline_pkg::*;
(
  input  wire id_ex_t                 id_ex_i,
  input  wire logic [`REG_ADDR_W-1:0] rs1_addr_i,
  input  wire logic [`REG_ADDR_W-1:0] rs2_addr_i,
  input  wire ex_mem_t                ex_mem_i,
  input  wire mem_wb_t                mem_wb_i,
  input  wire logic                   branch_taken_i,
  output fwd_sel_e                    fwd_a_o,
  output fwd_sel_e                    fwd_b_o,
  output logic                        stall_o,
  output logic                        flush_o
);

  logic load_use;

  // Youngest producer wins; reg_write already implies rd is not x0
  function automatic fwd_sel_e pick(input logic [`REG_ADDR_W-1:0] src,
                                    input ex_mem_t em,
                                    input mem_wb_t mw);
    if (em.reg_write && em.rd == src) begin
      return FWD_MEM;
    end else if (mw.reg_write && mw.rd == src) begin
      return FWD_WB;
    end else begin
      return FWD_NONE;
    end
  endfunction

  assign fwd_a_o = pick(id_ex_i.rs1, ex_mem_i, mem_wb_i);
  assign fwd_b_o = pick(id_ex_i.rs2, ex_mem_i, mem_wb_i);

  // Load result is not ready until writeback
  assign load_use = id_ex_i.valid && id_ex_i.mem_read && id_ex_i.reg_write &&
                    (id_ex_i.rd == rs1_addr_i || id_ex_i.rd == rs2_addr_i);

  assign flush_o = branch_taken_i;
  assign stall_o = load_use && !branch_taken_i;

endmodule

`default_nettype wire

/* source/cpu_core.sv */
`default_nettype none

`include "core_defines.svh"

module cpu_core
  import pipeline_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic [`XLEN-1:0]       inst_i,
  output logic      [`XLEN-1:0]       fetch_pc_o,
  output logic                        wb_valid_o,
  output logic      [`REG_ADDR_W-1:0] wb_rd_o,
  output logic      [`XLEN-1:0]       wb_data_o
);

  if_id_t                 if_id;
  id_ex_t                 id_ex;
  ex_mem_t                ex_mem;
  mem_wb_t                mem_wb;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  fwd_sel_e               fwd_a;
  fwd_sel_e               fwd_b;
  logic                   stall;
  logic                   flush;
  logic                   branch_taken;
  logic [`XLEN-1:0]       branch_target;

  // ==========================================================
  // Front end
  // ==========================================================
  fetch_stage fetch_stage_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .inst_i    (inst_i),
    .stall_i   (stall),
    .flush_i   (flush),
    .target_i  (branch_target),
    .fetch_pc_o(fetch_pc_o),
    .if_id_o   (if_id)
  );

  decode_stage decode_stage_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .if_id_i   (if_id),
    .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data),
    .stall_i   (stall),
    .flush_i   (flush),
    .rs1_addr_o(rs1_addr),
    .rs2_addr_o(rs2_addr),
    .id_ex_o   (id_ex)
  );

  // Written from writeback, read from decode
  register_file register_file_i (
    .clk_i     (clk_i),
    .rs1_addr_i(rs1_addr),
    .rs2_addr_i(rs2_addr),
    .wb_i      (mem_wb),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data)
  );

  // ==========================================================
  // Back end
  // ==========================================================
  execute_stage execute_stage_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .id_ex_i       (id_ex),
    .fwd_a_i       (fwd_a),
    .fwd_b_i       (fwd_b),
    .mem_fwd_i     (ex_mem.alu_result),
    .wb_i          (mem_wb),
    .branch_taken_o(branch_taken),
    .target_o      (branch_target),
    .ex_mem_o      (ex_mem)
  );

  memory_stage memory_stage_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .ex_mem_i(ex_mem),
    .mem_wb_o(mem_wb)
  );

  hazard_control hazard_control_i (
    .id_ex_i       (id_ex),
    .rs1_addr_i    (rs1_addr),
    .rs2_addr_i    (rs2_addr),
    .ex_mem_i      (ex_mem),
    .mem_wb_i      (mem_wb),
    .branch_taken_i(branch_taken),
    .fwd_a_o       (fwd_a),
    .fwd_b_o       (fwd_b),
    .stall_o       (stall),
    .flush_o       (flush)
  );

  // Retirement port
  assign wb_valid_o = mem_wb.reg_write;
  assign wb_rd_o    = mem_wb.rd;
  assign wb_data_o  = mem_wb.wb_data;

endmodule

`default_nettype wire

/* verification/isa_model.svh */
function automatic logic [31:0] sext12(input logic [11:0] v);
  return {{20{v[11]}}, v};
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] x, input logic [31:0] y);
  case (f3)
    F3_ADD_SUB: return alt ? x - y : x + y;
    F3_SLT:     return {31'd0, $signed(x) < $signed(y)};
    F3_XOR:     return x ^ y;
    F3_OR:      return x | y;
    F3_AND:     return x & y;
    default:    return x + y;
  endcase
endfunction

// One instruction per step, in program order, until the self-branch
task automatic run_reference();
  logic [31:0] regs [32];
  logic [31:0] dmem [256];
  logic [31:0] pc;
  logic [31:0] pc_next;
  logic [31:0] inst;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] addr;
  logic [31:0] result;
  logic [31:0] imm_b;
  logic        writes;
  logic        halted;
  wb_pair_t    pair;

  for (int r = 0; r < 32; r++) begin
    regs[5'(r)] = '0;
  end
  pc     = `RESET_PC;
  halted = 1'b0;
  for (int step = 0; step < ROM_WORDS && !halted; step++) begin
    inst = rom[pc[7:2]];
    if (inst == SELF_BRANCH) begin
      halted = 1'b1;
    end else begin
      a       = regs[inst[19:15]];
      b       = regs[inst[24:20]];
      writes  = 1'b0;
      result  = '0;
      pc_next = pc + 32'd4;
      case (inst[6:0])
        OP: begin
          writes = 1'b1;
          result = alu_ref(inst[14:12], inst[30], a, b);
        end
        OP_IMM: begin
          writes = 1'b1;
          result = alu_ref(inst[14:12], 1'b0, a, sext12(inst[31:20]));
        end
        LOAD: begin
          addr   = a + sext12(inst[31:20]);
          writes = 1'b1;
          result = dmem[addr[9:2]];
        end
        STORE: begin
          addr = a + sext12({inst[31:25], inst[11:7]});
          dmem[addr[9:2]] = b;
        end
        BRANCH: begin
          imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
          if ((inst[14:12] == F3_BNE) ? (a != b) : (a == b)) begin
            pc_next = pc + imm_b;
          end
        end
        default: ;
      endcase
      // x0 stays zero and produces no writeback
      if (writes && inst[11:7] != 5'd0) begin
        regs[inst[11:7]] = result;
        pair.rd   = inst[11:7];
        pair.data = result;
        expected_q.push_back(pair);
      end
      pc = pc_next;
    end
  end
endtask

/* verification/cpu_core_tb.sv */
`default_nettype none

`include "core_defines.svh"

module cpu_core_tb
  import isa_pkg::*;
();

  localparam int          ROM_WORDS    = 64;
  localparam int          CYCLE_LIMIT  = 3 * ROM_WORDS + 20;
  localparam int          DRAIN_CYCLES = 8;
  // BEQ x0, x0, 0
  localparam logic [31:0] SELF_BRANCH  = 32'h0000_0063;

  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } wb_pair_t;

  logic                   clk_i;
  logic                   rst_i;
  logic [`XLEN-1:0]       inst_i;
  logic [`XLEN-1:0]       fetch_pc_o;
  logic                   wb_valid_o;
  logic [`REG_ADDR_W-1:0] wb_rd_o;
  logic [`XLEN-1:0]       wb_data_o;

  logic [31:0] rom [ROM_WORDS];
  wb_pair_t    expected_q [$];
  wb_pair_t    expected;
  integer      seed;
  int          cycle_count;
  int          idle_cycles;
  int          retired;

  cpu_core cpu_core_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .inst_i    (inst_i),
    .fetch_pc_o(fetch_pc_o),
    .wb_valid_o(wb_valid_o),
    .wb_rd_o   (wb_rd_o),
    .wb_data_o (wb_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ============================================================
  // Reporting
  // ============================================================
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic compare_values(input string name, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      fail_run($sformatf("CHECK FAILED: %s expected 0x%08h actual 0x%08h",
                         name, exp_val, act_val));
    end
  endtask

  // ============================================================
  // Program generation
  // ============================================================
  function automatic int unsigned pick_below(input int unsigned n);
    int unsigned r;
    r = $unsigned($random(seed));
    return r % n;
  endfunction

  // Only x0..x7 so that dependencies are dense
  function automatic logic [4:0] pick_reg();
    return 5'(pick_below(8));
  endfunction

  function automatic logic [2:0] pick_alu_f3();
    case (pick_below(5))
      0:       return F3_ADD_SUB;
      1:       return F3_SLT;
      2:       return F3_XOR;
      3:       return F3_OR;
      default: return F3_AND;
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input opcode_e opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
  endfunction

  task automatic build_program();
    int unsigned kind;
    int unsigned span;
    logic [2:0]  f3;
    logic [6:0]  f7;

    // Preamble gives x1..x7 and the four data words known values
    for (int i = 0; i < 7; i++) begin
      rom[6'(i)] = enc_i(12'(pick_below(4096)), 5'd0, F3_ADD_SUB, 5'(i + 1), OP_IMM);
    end
    for (int i = 0; i < 4; i++) begin
      rom[6'(7 + i)] = enc_s(12'(4 * i), pick_reg(), 5'd0);
    end
    for (int i = 11; i < ROM_WORDS - 1; i++) begin
      kind = pick_below(10);
      if (kind >= 7 && i <= ROM_WORDS - 3) begin
        // Forward only and never past the self-branch
        span = 2 + pick_below(3);
        if (i + span > ROM_WORDS - 1) begin
          span = ROM_WORDS - 1 - i;
        end
        f3 = (pick_below(2) != 0) ? F3_BNE : F3_BEQ;
        rom[6'(i)] = enc_b(13'(4 * span), pick_reg(), pick_reg(), f3);
      end else if (kind <= 2) begin
        f3 = pick_alu_f3();
        f7 = (f3 == F3_ADD_SUB && pick_below(2) != 0) ? F7_SUB : F7_BASE;
        rom[6'(i)] = enc_r(f7, pick_reg(), pick_reg(), f3, pick_reg());
      end else if (kind == 5) begin
        rom[6'(i)] = enc_i(12'(4 * pick_below(4)), 5'd0, F3_WORD, pick_reg(), LOAD);
      end else if (kind == 6) begin
        rom[6'(i)] = enc_s(12'(4 * pick_below(4)), pick_reg(), 5'd0);
      end else begin
        rom[6'(i)] = enc_i(12'(pick_below(4096)), pick_reg(), pick_alu_f3(), pick_reg(),
                           OP_IMM);
      end
    end
    rom[6'(ROM_WORDS - 1)] = SELF_BRANCH;
  endtask

  `include "isa_model.svh"

  // Synchronous ROM where anything outside the program reads as a NOP
  function automatic logic [31:0] fetch_word(input logic [31:0] pc);
    if (pc < 32'(ROM_WORDS * 4) && pc[1:0] == 2'b00) begin
      return rom[pc[7:2]];
    end else begin
      return `NOP_INST;
    end
  endfunction

  always @(posedge clk_i) begin
    #1;
    inst_i = fetch_word(fetch_pc_o);
  end

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    seed        = 7;
    rst_i       = 1'b1;
    inst_i      = `NOP_INST;
    cycle_count = 0;
    idle_cycles = 0;
    retired     = 0;
    build_program();
    run_reference();

    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    compare_values("reset fetch_pc", `RESET_PC, fetch_pc_o);
    compare_values("reset wb_valid", 32'd0, 32'(wb_valid_o));

    // Writebacks sampled mid-cycle away from the clock edge
    while (idle_cycles < DRAIN_CYCLES) begin
      @(negedge clk_i);
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
        fail_run($sformatf("Timeout after %0d cycles, %0d writebacks never arrived",
                           cycle_count, expected_q.size()));
      end else if (wb_valid_o) begin
        if (expected_q.size() == 0) begin
          fail_run("A writeback arrived after every expected register write had retired");
        end else begin
          expected = expected_q.pop_front();
          compare_values($sformatf("writeback %0d rd", retired), 32'(expected.rd),
                         32'(wb_rd_o));
          compare_values($sformatf("writeback %0d data", retired), expected.data,
                         wb_data_o);
          retired++;
        end
      end else if (expected_q.size() == 0) begin
        idle_cycles++;
      end
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+source
+incdir+verification
source/isa_pkg.sv
source/pipeline_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/memory_stage.sv
source/hazard_control.sv
source/cpu_core.sv
verification/cpu_core_tb.sv

/* Makefile */
BIN  := obj_dir/Vcpu_core_tb
SRCS := $(wildcard source/*.sv source/*.svh verification/*.sv verification/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): sim.f $(SRCS)
	verilator --binary -f sim.f --top-module cpu_core_tb -Mdir obj_dir -o Vcpu_core_tb

run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log
	@if grep -q "Finished with no errors" sim.log; then echo "RUN PASSED"; \
	else echo "RUN FAILED"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
